// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - src/mem_pkg.sv
  - src/exc_if.sv
  - src/data_addr_check.sv
  - src/memsig_adjust.sv
  - src/rdata_extend.sv
  - src/exc_handler.sv
  - src/cp0_regfile.sv
  - src/mem_stage.sv
  - target: test
    files:
      - sim/tb_mem_stage.sv

// ==== list.f ====
src/mem_pkg.sv
src/exc_if.sv
src/data_addr_check.sv
src/memsig_adjust.sv
src/rdata_extend.sv
src/exc_handler.sv
src/cp0_regfile.sv
src/mem_stage.sv
sim/tb_mem_stage.sv

// ==== sim/tb_mem_stage.sv ====
`timescale 1ns/1ps

module tb_mem_stage;

	localparam int PERIOD = 8;
	localparam int N_ST   = 120;
	localparam int N_LD   = 120;
	localparam int N_REG  = 40;
	localparam int N_VEC  = N_ST + N_LD + 2 * N_REG + 120;

	typedef struct packed {
		logic        wr;
		logic [1:0]  size;
		logic [31:0] addr;
		logic [31:0] wdata;
	} store_exp_t;

	typedef struct packed {
		logic        valid;
		logic        take;
		logic [4:0]  code;
		logic [31:0] target;
	} exc_exp_t;

	logic clk;
	logic rst_n;
	logic stall;
	logic [5:0] ext_int;
	logic valid;
	mem_pkg::mem_op_t op;
	logic [31:0] addr;
	logic [31:0] rt_data;
	logic [31:0] pc;
	logic in_delay_slot;
	logic syscall;
	logic brk;
	logic eret;
	logic mtc0;
	logic mfc0;
	mem_pkg::cp0_addr_t cp0_reg;
	logic [31:0] data_rdata;
	logic data_req;
	logic data_wr;
	logic [1:0] data_size;
	logic [31:0] data_addr;
	logic [31:0] data_wdata;
	logic [31:0] load_result;
	logic [31:0] cp0_rdata;
	logic exc_valid;
	logic [31:0] exc_target;
	logic [31:0] epc;

	// Shadow CP0
	logic [31:0] sh_status;
	logic [31:0] sh_epc;
	logic [31:0] sh_badvaddr;
	logic [5:0]  sh_ip_hw;
	logic [1:0]  sh_ip_sw;
	logic [4:0]  sh_code;
	logic        sh_bd;
	logic        sh_fault;
	exc_exp_t    sh_exc;

	logic        mon_fault;
	logic        mon_req;
	store_exp_t  mon_st;
	exc_exp_t    mon_exc;

	int          errors;
	string       test_name;
	logic        checking;
	logic [31:0] rng;
	logic [31:0] val;

	mem_pkg::mem_op_t store_ops [5] = '{mem_pkg::MEM_SB, mem_pkg::MEM_SH, mem_pkg::MEM_SW,
		mem_pkg::MEM_SWL, mem_pkg::MEM_SWR};
	mem_pkg::mem_op_t load_ops [7] = '{mem_pkg::MEM_LB, mem_pkg::MEM_LBU, mem_pkg::MEM_LH,
		mem_pkg::MEM_LHU, mem_pkg::MEM_LW, mem_pkg::MEM_LWL, mem_pkg::MEM_LWR};
	mem_pkg::mem_op_t bad_ops [4] = '{mem_pkg::MEM_LH, mem_pkg::MEM_LW, mem_pkg::MEM_SH,
		mem_pkg::MEM_SW};
	mem_pkg::cp0_addr_t cp0_regs [4] = '{mem_pkg::CP0_STATUS, mem_pkg::CP0_CAUSE,
		mem_pkg::CP0_EPC, mem_pkg::CP0_BADVADDR};

	mem_stage #(.INT_LINES(6)) UUT (
		.clk (clk), .rst_n (rst_n), .stall (stall), .ext_int (ext_int), .valid (valid),
		.op (op), .addr (addr), .rt_data (rt_data), .pc (pc), .in_delay_slot (in_delay_slot),
		.syscall (syscall), .brk (brk), .eret (eret), .mtc0 (mtc0), .mfc0 (mfc0),
		.cp0_reg (cp0_reg), .data_rdata (data_rdata), .data_req (data_req),
		.data_wr (data_wr), .data_size (data_size), .data_addr (data_addr),
		.data_wdata (data_wdata), .load_result (load_result), .cp0_rdata (cp0_rdata),
		.exc_valid (exc_valid), .exc_target (exc_target), .epc (epc)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic is_st(input mem_pkg::mem_op_t o);
		return o inside {mem_pkg::MEM_SB, mem_pkg::MEM_SH, mem_pkg::MEM_SW,
			mem_pkg::MEM_SWL, mem_pkg::MEM_SWR};
	endfunction

	function automatic logic misaligned(input mem_pkg::mem_op_t o, input logic [31:0] a);
		case (o)
			mem_pkg::MEM_LH, mem_pkg::MEM_LHU, mem_pkg::MEM_SH: return a[0];
			mem_pkg::MEM_LW, mem_pkg::MEM_SW: return a[1:0] != 2'd0;
			default: return 1'b0;
		endcase
	endfunction

	// Bus request fields, stores and loads alike
	function automatic store_exp_t ref_store(input mem_pkg::mem_op_t o, input logic [31:0] a,
		input logic [31:0] rt);
		store_exp_t e;
		int k;
		k = int'(a[1:0]);
		e.wr = is_st(o);
		e.size = 2'd2;
		e.addr = a;
		e.wdata = rt;
		case (o)
			mem_pkg::MEM_SB, mem_pkg::MEM_LB, mem_pkg::MEM_LBU: begin
				e.size = 2'd0;
				e.wdata = {4{rt[7:0]}};
			end
			mem_pkg::MEM_SH, mem_pkg::MEM_LH, mem_pkg::MEM_LHU: begin
				e.size = 2'd1;
				e.wdata = {2{rt[15:0]}};
			end
			mem_pkg::MEM_SWL: begin
				e.addr = {a[31:2], 2'b00};
				e.wdata = rt >> (8 * (3 - k));
				e.size = (k == 0) ? 2'd0 : (k == 1) ? 2'd1 : 2'd2;
			end
			mem_pkg::MEM_SWR: begin
				e.wdata = rt << (8 * k);
				e.size = (k == 3) ? 2'd0 : (k == 2) ? 2'd1 : 2'd2;
			end
			default: ;
		endcase
		return e;
	endfunction

	function automatic logic [31:0] ref_load(input mem_pkg::mem_op_t o, input logic [1:0] off,
		input logic [31:0] rd, input logic [31:0] rt);
		logic [31:0] s;
		int k;
		k = int'(off);
		s = rd >> (8 * k);
		case (o)
			mem_pkg::MEM_LB:  return {{24{s[7]}}, s[7:0]};
			mem_pkg::MEM_LBU: return {24'b0, s[7:0]};
			mem_pkg::MEM_LH:  return {{16{s[15]}}, s[15:0]};
			mem_pkg::MEM_LHU: return {16'b0, s[15:0]};
			mem_pkg::MEM_LW:  return rd;
			mem_pkg::MEM_LWL: return (rd << (8 * (3 - k))) | (rt & ((32'h1 << (8 * (3 - k))) - 1));
			mem_pkg::MEM_LWR: return s | (rt & ~(32'hffff_ffff >> (8 * k)));
			default:          return 32'h0;
		endcase
	endfunction

	function automatic exc_exp_t ref_exc(input logic v, input logic fault,
		input mem_pkg::mem_op_t o, input logic sys, input logic bk, input logic er,
		input logic [31:0] st, input logic [31:0] ca, input logic [31:0] ep);
		exc_exp_t e;
		logic intp;
		intp = v & st[0] & ~st[1] & (|(ca[15:8] & st[15:8]));
		e.take = intp | (v & (fault | sys | bk));
		if (intp) begin
			e.code = mem_pkg::EXC_INT;
		end else if (fault) begin
			e.code = is_st(o) ? mem_pkg::EXC_ADES : mem_pkg::EXC_ADEL;
		end else if (sys) begin
			e.code = mem_pkg::EXC_SYS;
		end else begin
			e.code = mem_pkg::EXC_BP;
		end
		e.valid = e.take | (v & er);
		e.target = e.take ? mem_pkg::EXC_VECTOR : ep;
		return e;
	endfunction

	function automatic logic [31:0] shadow_cause();
		return {sh_bd, 15'b0, sh_ip_hw, sh_ip_sw, 1'b0, sh_code, 2'b00};
	endfunction

	function automatic logic [31:0] shadow_read(input mem_pkg::cp0_addr_t r);
		case (r)
			mem_pkg::CP0_BADVADDR: return sh_badvaddr;
			mem_pkg::CP0_STATUS:   return sh_status;
			mem_pkg::CP0_CAUSE:    return shadow_cause();
			mem_pkg::CP0_EPC:      return sh_epc;
			default:               return 32'h0;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("FAIL %s %s: expected %h, actual %h", test_name, name, expected, actual);
		end
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sh_status   <= 32'h0000_0002;
			sh_epc      <= '0;
			sh_badvaddr <= '0;
			sh_ip_hw    <= '0;
			sh_ip_sw    <= '0;
			sh_code     <= '0;
			sh_bd       <= 1'b0;
		end else begin
			sh_fault = valid & misaligned(op, addr);
			sh_exc = ref_exc(valid, sh_fault, op, syscall, brk, eret, sh_status,
				shadow_cause(), sh_epc);
			sh_ip_hw <= ext_int;
			if (!stall) begin
				if (sh_exc.take) begin
					sh_status[1] <= 1'b1;
					sh_code      <= sh_exc.code;
					sh_bd        <= in_delay_slot;
					sh_epc       <= in_delay_slot ? pc - 32'd4 : pc;
					if (sh_fault && sh_exc.code != mem_pkg::EXC_INT) begin
						sh_badvaddr <= addr;
					end
				end else if (valid && eret) begin
					sh_status[1] <= 1'b0;
				end else if (valid && mtc0) begin
					case (cp0_reg)
						mem_pkg::CP0_STATUS: sh_status <= (sh_status & ~32'h0000_ff03) |
							(rt_data & 32'h0000_ff03);
						mem_pkg::CP0_CAUSE: sh_ip_sw <= rt_data[9:8];
						mem_pkg::CP0_EPC: sh_epc <= rt_data;
						default: ;
					endcase
				end
			end
		end
	end

	// Compare one nanosecond before each rising edge
	initial begin
		forever begin
			@(negedge clk);
			#3;
			if (checking) begin
				mon_fault = valid & misaligned(op, addr);
				mon_req = valid & (op != mem_pkg::MEM_NONE) & ~mon_fault;
				mon_st = ref_store(op, addr, rt_data);
				mon_exc = ref_exc(valid, mon_fault, op, syscall, brk, eret, sh_status,
					shadow_cause(), sh_epc);
				check("data_req", mon_req, data_req);
				if (mon_req) begin
					check("data_wr", mon_st.wr, data_wr);
					check("data_size", mon_st.size, data_size);
					check("data_addr", mon_st.addr, data_addr);
					if (mon_st.wr) begin
						check("data_wdata", mon_st.wdata, data_wdata);
					end else begin
						check("load_result", ref_load(op, addr[1:0], data_rdata, rt_data),
							load_result);
					end
				end
				check("exc_valid", mon_exc.valid, exc_valid);
				if (mon_exc.valid) begin
					check("exc_target", mon_exc.target, exc_target);
				end
				check("cp0_rdata", (valid && mfc0) ? shadow_read(cp0_reg) : 32'h0, cp0_rdata);
				check("epc", sh_epc, epc);
			end
		end
	end

	initial begin
		#((N_VEC + 100) * PERIOD);
		$display("Watchdog expired, the simulation hung");
		$display("Regression failed");
		$finish;
	end

	task automatic rand_word(output logic [31:0] w);
		rng = xorshift(rng);
		w = rng;
	endtask

	// Stall and ext_int persist across vectors
	task automatic next_vec();
		@(negedge clk);
		valid = 1'b0;
		op = mem_pkg::MEM_NONE;
		addr = '0;
		rt_data = '0;
		pc = '0;
		in_delay_slot = 1'b0;
		syscall = 1'b0;
		brk = 1'b0;
		eret = 1'b0;
		mtc0 = 1'b0;
		mfc0 = 1'b0;
		cp0_reg = '0;
		data_rdata = '0;
	endtask

	task automatic read_cp0(input mem_pkg::cp0_addr_t r);
		next_vec();
		valid = 1'b1;
		mfc0 = 1'b1;
		cp0_reg = r;
	endtask

	task automatic write_cp0(input mem_pkg::cp0_addr_t r, input logic [31:0] w);
		next_vec();
		valid = 1'b1;
		mtc0 = 1'b1;
		cp0_reg = r;
		rt_data = w;
	endtask

	task automatic instr(input logic sys, input logic bk, input logic er);
		next_vec();
		valid = 1'b1;
		syscall = sys;
		brk = bk;
		eret = er;
		rand_word(pc);
		pc[1:0] = 2'b00;
	endtask

	initial begin
		rst_n = 1'b0;
		stall = 1'b0;
		ext_int = '0;
		valid = 1'b0;
		op = mem_pkg::MEM_NONE;
		addr = '0;
		rt_data = '0;
		pc = '0;
		in_delay_slot = 1'b0;
		syscall = 1'b0;
		brk = 1'b0;
		eret = 1'b0;
		mtc0 = 1'b0;
		mfc0 = 1'b0;
		cp0_reg = '0;
		data_rdata = '0;
		errors = 0;
		checking = 1'b0;
		rng = 32'd25;
		test_name = "reset";
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		checking = 1'b1;
		read_cp0(mem_pkg::CP0_STATUS);
		read_cp0(mem_pkg::CP0_CAUSE);

		test_name = "store";
		for (int i = 0; i < N_ST + 8; i++) begin
			next_vec();
			valid = 1'b1;
			rand_word(addr);
			rand_word(rt_data);
			rand_word(data_rdata);
			rng = xorshift(rng);
			op = store_ops[rng % 5];
			// Directed SWL and SWR at every offset
			if (i >= N_ST) begin
				op = (i - N_ST < 4) ? mem_pkg::MEM_SWL : mem_pkg::MEM_SWR;
				addr[1:0] = 2'(i - N_ST);
			end
			if (op == mem_pkg::MEM_SH) addr[0] = 1'b0;
			if (op == mem_pkg::MEM_SW) addr[1:0] = 2'b00;
		end

		test_name = "load";
		for (int i = 0; i < N_LD; i++) begin
			next_vec();
			valid = 1'b1;
			rand_word(addr);
			rand_word(rt_data);
			rand_word(data_rdata);
			rng = xorshift(rng);
			op = load_ops[rng % 7];
			if (op inside {mem_pkg::MEM_LH, mem_pkg::MEM_LHU}) addr[0] = 1'b0;
			if (op == mem_pkg::MEM_LW) addr[1:0] = 2'b00;
		end

		test_name = "misaligned";
		for (int i = 0; i < 8; i++) begin
			instr(1'b0, 1'b0, 1'b0);
			op = bad_ops[i % 4];
			in_delay_slot = i[2];
			rand_word(addr);
			rand_word(rt_data);
			addr[0] = 1'b1;
			read_cp0(mem_pkg::CP0_BADVADDR);
			read_cp0(mem_pkg::CP0_CAUSE);
			read_cp0(mem_pkg::CP0_EPC);
		end

		test_name = "cp0_rw";
		for (int i = 0; i < N_REG; i++) begin
			rand_word(val);
			rng = xorshift(rng);
			// EXL stays set so no interrupt fires here
			if (cp0_regs[rng % 4] == mem_pkg::CP0_STATUS) val[1] = 1'b1;
			write_cp0(cp0_regs[rng % 4], val);
			read_cp0(cp0_reg);
		end
		write_cp0(mem_pkg::CP0_CAUSE, 32'h0);

		test_name = "interrupt";
		write_cp0(mem_pkg::CP0_STATUS, 32'h0000_ff01);
		next_vec();
		ext_int = 6'b000100;
		instr(1'b1, 1'b0, 1'b0);
		read_cp0(mem_pkg::CP0_CAUSE);
		read_cp0(mem_pkg::CP0_EPC);
		ext_int = '0;
		instr(1'b0, 1'b0, 1'b1);
		read_cp0(mem_pkg::CP0_STATUS);
		instr(1'b1, 1'b0, 1'b0);
		read_cp0(mem_pkg::CP0_CAUSE);
		instr(1'b0, 1'b0, 1'b1);
		instr(1'b0, 1'b1, 1'b0);
		read_cp0(mem_pkg::CP0_CAUSE);
		instr(1'b0, 1'b0, 1'b1);

		test_name = "stall";
		write_cp0(mem_pkg::CP0_STATUS, 32'h0000_0002);
		rand_word(val);
		write_cp0(mem_pkg::CP0_EPC, val);
		stall = 1'b1;
		write_cp0(mem_pkg::CP0_STATUS, 32'h0000_ff01);
		instr(1'b1, 1'b0, 1'b0);
		instr(1'b0, 1'b0, 1'b0);
		op = mem_pkg::MEM_LW;
		rand_word(addr);
		addr[0] = 1'b1;
		ext_int = 6'b101010;
		read_cp0(mem_pkg::CP0_CAUSE);
		read_cp0(mem_pkg::CP0_CAUSE);
		stall = 1'b0;
		read_cp0(mem_pkg::CP0_STATUS);
		read_cp0(mem_pkg::CP0_EPC);
		read_cp0(mem_pkg::CP0_BADVADDR);
		ext_int = '0;
		read_cp0(mem_pkg::CP0_CAUSE);

		next_vec();
		@(posedge clk);
		checking = 1'b0;
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== src/cp0_regfile.sv ====
`timescale 1ns/1ps

module cp0_regfile #(
	parameter int INT_LINES = 6
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stall,
	input  logic [INT_LINES-1:0] ext_int,
	input  logic                 mtc0,
	input  logic                 mfc0,
	input  mem_pkg::cp0_addr_t   reg_addr,
	input  mem_pkg::word_t       wdata,
	exc_if.cp0                   exc,
	output mem_pkg::word_t       rdata,
	output mem_pkg::word_t       status,
	output mem_pkg::word_t       cause,
	output mem_pkg::word_t       epc
);

	mem_pkg::word_t       badvaddr_q;
	mem_pkg::word_t       status_q;
	mem_pkg::word_t       epc_q;
	logic [INT_LINES-1:0] ip_hw_q;
	logic [1:0]           ip_sw_q;
	mem_pkg::exc_code_t   code_q;
	logic                 bd_q;
	mem_pkg::word_t       cause_wr;

	assign cause_wr = wdata & mem_pkg::CAUSE_WMASK;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			badvaddr_q <= '0;
			status_q   <= 32'h0000_0002;
			epc_q      <= '0;
			ip_hw_q    <= '0;
			ip_sw_q    <= '0;
			code_q     <= '0;
			bd_q       <= 1'b0;
		end else begin
			// Pending lines sample even during a stall
			ip_hw_q <= ext_int;
			if (!stall) begin
				if (exc.commit) begin
					status_q[1] <= 1'b1;
					code_q      <= exc.code;
					bd_q        <= exc.bd;
					epc_q       <= exc.epc;
					if (exc.has_badvaddr) begin
						badvaddr_q <= exc.badvaddr;
					end
				end else if (exc.eret) begin
					status_q[1] <= 1'b0;
				end else if (mtc0) begin
					case (reg_addr)
						mem_pkg::CP0_STATUS: begin
							status_q <= (status_q & ~mem_pkg::STATUS_WMASK) |
								(wdata & mem_pkg::STATUS_WMASK);
						end
						mem_pkg::CP0_CAUSE: ip_sw_q <= cause_wr[9:8];
						mem_pkg::CP0_EPC:   epc_q   <= wdata;
						default: ;
					endcase
				end
			end
		end
	end

	always_comb begin
		cause                  = '0;
		cause[31]              = bd_q;
		cause[9+INT_LINES:10]  = ip_hw_q;
		cause[9:8]             = ip_sw_q;
		cause[6:2]             = code_q;
	end

	assign status = status_q;
	assign epc    = epc_q;

	always_comb begin
		rdata = '0;
		if (mfc0) begin
			case (reg_addr)
				mem_pkg::CP0_BADVADDR: rdata = badvaddr_q;
				mem_pkg::CP0_STATUS:   rdata = status_q;
				mem_pkg::CP0_CAUSE:    rdata = cause;
				mem_pkg::CP0_EPC:      rdata = epc_q;
				default:               rdata = '0;
			endcase
		end
	end

	// Top level must block mtc0 whenever an exception is taken
	a_commit_mtc0_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(exc.commit && mtc0 && !stall))
		else $error("exception commit and mtc0 in the same edge");

endmodule

// ==== src/data_addr_check.sv ====
`timescale 1ns/1ps

module data_addr_check (
	input  mem_pkg::mem_op_t   op,
	input  logic               valid,
	input  mem_pkg::word_t     addr,
	output logic               req,
	output logic               addr_err,
	output mem_pkg::exc_code_t err_code,
	output mem_pkg::word_t     badvaddr
);

	logic misalign;
	logic is_st;

	always_comb begin
		case (op)
			mem_pkg::MEM_LH, mem_pkg::MEM_LHU, mem_pkg::MEM_SH: begin
				misalign = addr[0];
			end
			mem_pkg::MEM_LW, mem_pkg::MEM_SW: begin
				misalign = |addr[1:0];
			end
			// Byte and unaligned word ops never fault
			default: begin
				misalign = 1'b0;
			end
		endcase
	end

	assign is_st    = mem_pkg::is_store(op);
	assign addr_err = valid & misalign;
	assign err_code = is_st ? mem_pkg::EXC_ADES : mem_pkg::EXC_ADEL;
	assign badvaddr = addr;

	assign req = valid & (op != mem_pkg::MEM_NONE) & ~misalign;

	a_no_req_on_err: assert final ((req & addr_err) !== 1'b1)
		else $error("data request issued with address error");

endmodule

// ==== src/exc_handler.sv ====
`timescale 1ns/1ps

module exc_handler #(
	parameter int INT_LINES = 6
) (
	input  logic               valid,
	input  logic               in_delay_slot,
	input  mem_pkg::word_t     pc,
	input  logic               addr_err,
	input  mem_pkg::exc_code_t err_code,
	input  mem_pkg::word_t     badvaddr,
	input  logic               syscall,
	input  logic               brk,
	input  logic               eret,
	input  mem_pkg::word_t     status,
	input  mem_pkg::word_t     cause,
	input  mem_pkg::word_t     epc,
	output logic               exc_valid,
	output mem_pkg::word_t     exc_target,
	exc_if.handler             exc
);

	localparam int IP_TOP = 9 + INT_LINES;

	logic               int_pend;
	logic               take_exc;
	logic               do_eret;
	mem_pkg::exc_code_t code;

	// IE set, EXL clear, some enabled line pending
	assign int_pend = valid & status[0] & ~status[1] &
		(|(cause[IP_TOP:8] & status[IP_TOP:8]));

	assign take_exc = int_pend | (valid & (addr_err | syscall | brk));

	always_comb begin
		if (int_pend) begin
			code = mem_pkg::EXC_INT;
		end else if (addr_err) begin
			code = err_code;
		end else if (syscall) begin
			code = mem_pkg::EXC_SYS;
		end else begin
			code = mem_pkg::EXC_BP;
		end
	end

	assign do_eret    = valid & eret & ~take_exc;
	assign exc_valid  = take_exc | do_eret;
	assign exc_target = take_exc ? mem_pkg::EXC_VECTOR : epc;

	assign exc.commit       = take_exc;
	assign exc.code         = code;
	// Branch gets restarted for a delay slot
	assign exc.epc          = in_delay_slot ? pc - 32'd4 : pc;
	assign exc.bd           = in_delay_slot;
	assign exc.badvaddr     = badvaddr;
	assign exc.has_badvaddr = ~int_pend & valid & addr_err;
	assign exc.eret         = do_eret;

endmodule

// ==== src/exc_if.sv ====
`timescale 1ns/1ps

interface exc_if;

	logic                commit;
	mem_pkg::exc_code_t  code;
	mem_pkg::word_t      epc;
	logic                bd;
	mem_pkg::word_t      badvaddr;
	logic                has_badvaddr;
	logic                eret;

	modport handler (
		output commit, code, epc, bd, badvaddr, has_badvaddr, eret
	);

	// CP0 samples these on the clock edge
	modport cp0 (
		input commit, code, epc, bd, badvaddr, has_badvaddr, eret
	);

endinterface

// ==== src/mem_pkg.sv ====
package mem_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  exc_code_t;
	typedef logic [4:0]  cp0_addr_t;

	typedef enum logic [3:0] {
		MEM_NONE,
		MEM_LB,
		MEM_LBU,
		MEM_LH,
		MEM_LHU,
		MEM_LW,
		MEM_LWL,
		MEM_LWR,
		MEM_SB,
		MEM_SH,
		MEM_SW,
		MEM_SWL,
		MEM_SWR
	} mem_op_t;

	localparam exc_code_t EXC_INT  = 5'd0;
	localparam exc_code_t EXC_ADEL = 5'd4;
	localparam exc_code_t EXC_ADES = 5'd5;
	localparam exc_code_t EXC_SYS  = 5'd8;
	localparam exc_code_t EXC_BP   = 5'd9;

	localparam cp0_addr_t CP0_BADVADDR = 5'd8;
	localparam cp0_addr_t CP0_STATUS   = 5'd12;
	localparam cp0_addr_t CP0_CAUSE    = 5'd13;
	localparam cp0_addr_t CP0_EPC      = 5'd14;

	localparam word_t EXC_VECTOR = 32'hbfc0_0380;

	// IM[15:8], EXL and IE
	localparam word_t STATUS_WMASK = 32'h0000_ff03;
	// Software interrupt bits only
	localparam word_t CAUSE_WMASK  = 32'h0000_0300;

	function automatic logic is_load(mem_op_t op);
		return op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_LWL, MEM_LWR};
	endfunction

	function automatic logic is_store(mem_op_t op);
		return op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SWL, MEM_SWR};
	endfunction

endpackage

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage #(
	parameter int INT_LINES = 6
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stall,
	input  logic [INT_LINES-1:0] ext_int,
	input  logic                 valid,
	input  mem_pkg::mem_op_t     op,
	input  mem_pkg::word_t       addr,
	input  mem_pkg::word_t       rt_data,
	input  mem_pkg::word_t       pc,
	input  logic                 in_delay_slot,
	input  logic                 syscall,
	input  logic                 brk,
	input  logic                 eret,
	input  logic                 mtc0,
	input  logic                 mfc0,
	input  mem_pkg::cp0_addr_t   cp0_reg,
	input  mem_pkg::word_t       data_rdata,
	output logic                 data_req,
	output logic                 data_wr,
	output logic [1:0]           data_size,
	output mem_pkg::word_t       data_addr,
	output mem_pkg::word_t       data_wdata,
	output mem_pkg::word_t       load_result,
	output mem_pkg::word_t       cp0_rdata,
	output logic                 exc_valid,
	output mem_pkg::word_t       exc_target,
	output mem_pkg::word_t       epc
);

	logic               addr_err;
	mem_pkg::exc_code_t err_code;
	mem_pkg::word_t     badvaddr;
	logic [1:0]         real_offset;
	mem_pkg::word_t     status;
	mem_pkg::word_t     cause;
	logic               mtc0_en;
	logic               mfc0_en;

	exc_if exc_bus ();

	data_addr_check u_addr_check (
		.op       (op),
		.valid    (valid),
		.addr     (addr),
		.req      (data_req),
		.addr_err (addr_err),
		.err_code (err_code),
		.badvaddr (badvaddr)
	);

	memsig_adjust u_memsig (
		.op          (op),
		.addr        (addr),
		.rt_data     (rt_data),
		.wr          (data_wr),
		.real_size   (data_size),
		.real_offset (real_offset),
		.wdata       (data_wdata)
	);

	// Word address with the lane offset of the adjusted store
	assign data_addr = {addr[31:2], real_offset};

	rdata_extend u_rdata (
		.op      (op),
		.offset  (addr[1:0]),
		.rdata   (data_rdata),
		.rt_data (rt_data),
		.result  (load_result)
	);

	exc_handler #(.INT_LINES(INT_LINES)) u_exc (
		.valid         (valid),
		.in_delay_slot (in_delay_slot),
		.pc            (pc),
		.addr_err      (addr_err),
		.err_code      (err_code),
		.badvaddr      (badvaddr),
		.syscall       (syscall),
		.brk           (brk),
		.eret          (eret),
		.status        (status),
		.cause         (cause),
		.epc           (epc),
		.exc_valid     (exc_valid),
		.exc_target    (exc_target),
		.exc           (exc_bus.handler)
	);

	assign mtc0_en = valid & mtc0 & ~exc_valid;
	assign mfc0_en = valid & mfc0;

	cp0_regfile #(.INT_LINES(INT_LINES)) u_cp0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.stall    (stall),
		.ext_int  (ext_int),
		.mtc0     (mtc0_en),
		.mfc0     (mfc0_en),
		.reg_addr (cp0_reg),
		.wdata    (rt_data),
		.exc      (exc_bus.cp0),
		.rdata    (cp0_rdata),
		.status   (status),
		.cause    (cause),
		.epc      (epc)
	);

endmodule

// ==== src/memsig_adjust.sv ====
`timescale 1ns/1ps

module memsig_adjust (
	input  mem_pkg::mem_op_t op,
	input  mem_pkg::word_t   addr,
	input  mem_pkg::word_t   rt_data,
	output logic             wr,
	output logic [1:0]       real_size,
	output logic [1:0]       real_offset,
	output mem_pkg::word_t   wdata
);

	logic [1:0] k;

	assign k  = addr[1:0];
	assign wr = mem_pkg::is_store(op);

	always_comb begin
		real_size   = 2'd2;
		real_offset = k;
		wdata       = rt_data;
		case (op)
			mem_pkg::MEM_LB, mem_pkg::MEM_LBU, mem_pkg::MEM_SB: begin
				real_size = 2'd0;
				wdata     = {4{rt_data[7:0]}};
			end
			mem_pkg::MEM_LH, mem_pkg::MEM_LHU, mem_pkg::MEM_SH: begin
				real_size = 2'd1;
				wdata     = {2{rt_data[15:0]}};
			end
			// Upper bytes of rt go to the low lanes
			mem_pkg::MEM_SWL: begin
				real_offset = 2'd0;
				case (k)
					2'd0: begin
						real_size = 2'd0;
						wdata     = {24'b0, rt_data[31:24]};
					end
					2'd1: begin
						real_size = 2'd1;
						wdata     = {16'b0, rt_data[31:16]};
					end
					2'd2: begin
						real_size = 2'd2;
						wdata     = {8'b0, rt_data[31:8]};
					end
					default: begin
						real_size = 2'd2;
						wdata     = rt_data;
					end
				endcase
			end
			mem_pkg::MEM_SWR: begin
				real_size = (k == 2'd3) ? 2'd0 : (k == 2'd2) ? 2'd1 : 2'd2;
				wdata     = rt_data << {k, 3'b000};
			end
			default: begin
				real_size = 2'd2;
			end
		endcase
	end

endmodule

// ==== src/rdata_extend.sv ====
`timescale 1ns/1ps

module rdata_extend (
	input  mem_pkg::mem_op_t op,
	input  logic [1:0]       offset,
	input  mem_pkg::word_t   rdata,
	input  mem_pkg::word_t   rt_data,
	output mem_pkg::word_t   result
);

	logic [7:0]     sel_byte;
	logic [15:0]    sel_half;
	mem_pkg::word_t shifted;
	mem_pkg::word_t lwl_data;
	mem_pkg::word_t lwr_data;

	assign shifted  = rdata >> {offset, 3'b000};
	assign sel_byte = shifted[7:0];
	assign sel_half = offset[1] ? rdata[31:16] : rdata[15:0];

	// Low memory bytes into the top of rt
	always_comb begin
		case (offset)
			2'd0:    lwl_data = {rdata[7:0], rt_data[23:0]};
			2'd1:    lwl_data = {rdata[15:0], rt_data[15:0]};
			2'd2:    lwl_data = {rdata[23:0], rt_data[7:0]};
			default: lwl_data = rdata;
		endcase
	end

	// Bytes from offset upward into the bottom of rt
	always_comb begin
		case (offset)
			2'd0:    lwr_data = rdata;
			2'd1:    lwr_data = {rt_data[31:24], rdata[31:8]};
			2'd2:    lwr_data = {rt_data[31:16], rdata[31:16]};
			default: lwr_data = {rt_data[31:8], rdata[31:24]};
		endcase
	end

	always_comb begin
		case (op)
			mem_pkg::MEM_LB:  result = {{24{sel_byte[7]}}, sel_byte};
			mem_pkg::MEM_LBU: result = {24'b0, sel_byte};
			mem_pkg::MEM_LH:  result = {{16{sel_half[15]}}, sel_half};
			mem_pkg::MEM_LHU: result = {16'b0, sel_half};
			mem_pkg::MEM_LW:  result = rdata;
			mem_pkg::MEM_LWL: result = lwl_data;
			mem_pkg::MEM_LWR: result = lwr_data;
			default:          result = '0;
		endcase
	end

	a_load_known: assert final ((mem_pkg::is_load(op) !== 1'b1) || !$isunknown(result))
		else $error("load result has unknown bits");

endmodule
